// File: verilog.f
design/bus_pkg.sv
design/sd_pkg.sv
design/bus_arbiter.sv
design/io_decoder.sv
design/sd_dispatcher.sv
design/backplane.sv
tb/tb_backplane.sv

// File: Bender.yml
package:
  name: backplane

sources:
  - design/bus_pkg.sv
  - design/sd_pkg.sv
  - design/bus_arbiter.sv
  - design/io_decoder.sv
  - design/sd_dispatcher.sv
  - design/backplane.sv
  - target: test
    files:
      - tb/tb_backplane.sv

// File: tb/tb_backplane.sv
//********************
// testbench of the backplane fabric
// lfsr stimulus, slave and sd client models,
// reference model and checks
//********************
module tb_backplane;

   import bus_pkg::*;
   import sd_pkg::*;

   logic wb_clk = 1'b0;
   logic rst_n_i;
   cpu_master_t cpu_m;
   dma_master_t rk_m, my_m;
   logic rk_req, my_req;
   logic cpu_gnt, rk_gnt, my_gnt, cpu_ack, rk_ack, my_ack;
   wb_dat_t rd_dat;
   slave_req_t bus;
   logic bus_cyc;
   slave_vec_t slv_stb, slv_ack, ack_next;
   slave_dat_t slv_dat;
   sd_vec_t sd_req, sd_cs, sd_mosi, sd_ack, ack_m;
   logic sdcard_cs, sdcard_mosi;
   logic [15:0] lfsr_q = 16'd1811;   // seed
   logic [2:0] dly_q;                // slave answer delay
   logic [2:0] hold [N_SD];          // sd client busy time
   int errors = 0;
   int checks = 0;
   int err_mark = 0;
   int grants = 0;

   backplane i_backplane (
      .wb_clk(wb_clk), .rst_n_i(rst_n_i), .cpu_m_i(cpu_m), .rk_req_i(rk_req), .rk_m_i(rk_m),
      .my_req_i(my_req), .my_m_i(my_m), .cpu_gnt_o(cpu_gnt), .rk_gnt_o(rk_gnt),
      .my_gnt_o(my_gnt), .cpu_ack_o(cpu_ack), .rk_ack_o(rk_ack), .my_ack_o(my_ack),
      .rd_dat_o(rd_dat), .bus_o(bus), .bus_cyc_o(bus_cyc), .slv_stb_o(slv_stb),
      .slv_ack_i(slv_ack), .slv_dat_i(slv_dat), .sd_req_i(sd_req), .sd_cs_i(sd_cs),
      .sd_mosi_i(sd_mosi), .sd_ack_o(sd_ack), .sdcard_cs_o(sdcard_cs),
      .sdcard_mosi_o(sdcard_mosi)
   );

   always #10 wb_clk = ~wb_clk;   // period 20

   // galois lfsr, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   // word a slave returns
   function automatic wb_dat_t slave_word(input int idx, input wb_adr_t adr);
      return wb_dat_t'((idx + 1) * 16'h1357) ^ adr;
   endfunction

   // reference address map, inclusive ranges
   function automatic slave_vec_t map_model(input wb_adr_t a);
      slave_vec_t m;
      m = '0;
      m[0] = (a < 16'o140000);
      m[1] = (a >= 16'o140000 && a <= 16'o157777);
      m[2] = (a >= 16'o177560 && a <= 16'o177567);
      m[3] = (a >= 16'o176500 && a <= 16'o176507);
      m[4] = (a >= 16'o177514 && a <= 16'o177517);
      m[5] = (a >= 16'o177400 && a <= 16'o177417);
      m[6] = (a >= 16'o174000 && a <= 16'o174037);
      m[7] = (a >= 16'o177170 && a <= 16'o177173);
      m[8] = (a >= 16'o172140 && a <= 16'o172143);
      m[9] = (a >= 16'o176640 && a <= 16'o176647);
      return m;
   endfunction

   function automatic int slave_index(input slave_vec_t m);
      for (int i = 0; i < N_SLAVES; i++) if (m[i]) return i;
      return -1;
   endfunction

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         $display("Error at %0t: %s, got %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic test_done(input string name);
      $display("test %s finished with %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   //********************
   // slave models
   //********************
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) slv_dat[i] = slave_word(i, bus.adr);
   end

   // decide at posedge on stable strobes, apply on the falling edge
   always @(posedge wb_clk) begin
      if (!rst_n_i) begin
         ack_next <= '0;
         dly_q    <= '0;
      end else if (slv_ack != 0) begin
         ack_next <= '0;                   // master drops stb now
      end else if (slv_stb != 0) begin
         if (dly_q == 0) ack_next <= slv_stb;
         else dly_q <= dly_q - 1;
      end else begin
         dly_q <= rand_bits(2);
      end
   end

   always @(negedge wb_clk) slv_ack <= ack_next;

   //********************
   // bus tasks
   //********************
   // one cpu access, waits for ack unless the address is unmapped
   task automatic cpu_access(input wb_adr_t adr, input logic we, input wb_sel_t sel,
                             input wb_dat_t wdat);
      slave_vec_t exp_stb;
      int idx;
      int t;
      exp_stb = map_model(adr);
      idx = slave_index(exp_stb);
      @(negedge wb_clk);
      cpu_m = '{adr: adr, dat: wdat, cyc: 1'b1, we: we, sel: sel, stb: 1'b1};
      @(posedge wb_clk);
      check_eq(bus_cyc, 1'b1, "cpu cycle on the bus");
      check_eq(slv_stb, exp_stb, "strobe decode");
      t = 0;
      while (idx >= 0 && !cpu_ack && t < 20) begin
         @(posedge wb_clk);
         t++;
      end
      if (idx >= 0 && !cpu_ack) begin
         $display("no acknowledge from the slave for the cpu at %0t", $time);
         errors++;
      end else if (idx >= 0 && !we) begin
         check_eq(rd_dat, slave_word(idx, adr), "read data");
      end else if (idx >= 0) begin
         check_eq({bus.dat, bus.sel, bus.we}, {wdat, sel, 1'b1}, "write data and sel");
      end
      @(negedge wb_clk);
      cpu_m.cyc = 1'b0;                    // also withdraws unmapped accesses
      cpu_m.stb = 1'b0;
   endtask

   // random address, mostly inside a window
   function automatic wb_adr_t pick_addr();
      case (rand_bits(4))
         0: return wb_adr_t'(rand_bits(16) % 16'o140000);
         1: return 16'o140000 + rand_bits(13);
         2: return 16'o177560 + rand_bits(3);
         3: return 16'o176500 + rand_bits(3);
         4: return 16'o177514 + rand_bits(2);
         5: return 16'o177400 + rand_bits(4);
         6: return 16'o174000 + rand_bits(5);
         7: return 16'o177170 + rand_bits(2);
         8: return 16'o172140 + rand_bits(2);
         9: return 16'o176640 + rand_bits(3);
         default: return 16'o160000 | rand_bits(13);   // anywhere in the i/o page
      endcase
   endfunction

   // waits for a grant line, gives up after a while
   task automatic wait_high(ref logic sig, input string what);
      int t;
      t = 0;
      while (!sig && t < 20) begin
         @(posedge wb_clk);
         t++;
      end
      if (!sig) begin
         $display("timed out waiting for %s at %0t", what, $time);
         errors++;
      end
   endtask

   // sd client step on the falling edge
   task automatic drive_clients();
      for (int i = 0; i < N_SD; i++) begin
         if (sd_req[i]) begin
            if (sd_ack[i] && hold[i] == 0) sd_req[i] = 1'b0;
            else if (sd_ack[i]) hold[i] = hold[i] - 1;
         end else if (!sd_ack[i] && rand_bits(2) == 0) begin
            sd_req[i] = 1'b1;
            hold[i]   = rand_bits(3);
         end
      end
      sd_cs   = rand_bits(4);
      sd_mosi = rand_bits(4);
   endtask

   //********************
   // main sequence
   //********************
   initial begin
      int t;
      int own;
      rst_n_i = 1'b0;
      cpu_m   = '0;
      rk_m    = '0;
      my_m    = '0;
      rk_req  = 1'b0;
      my_req  = 1'b0;
      slv_ack = '0;
      sd_req  = '0;
      sd_cs   = '0;
      sd_mosi = '0;
      ack_m   = '0;
      own     = 0;
      for (int i = 0; i < N_SD; i++) hold[i] = '0;
      repeat (3) @(posedge wb_clk);
      @(negedge wb_clk);
      rst_n_i = 1'b1;
      @(posedge wb_clk);
      check_eq({cpu_gnt, rk_gnt, my_gnt}, 3'b100, "grants after reset");
      check_eq({sd_ack, sdcard_cs, sdcard_mosi}, {4'b0, SD_IDLE_CS, SD_IDLE_MOSI}, "sd idle");
      test_done("reset");
      @(negedge wb_clk);                   // lfsr stepped away from the slave model edge

      for (int n = 0; n < 60; n++) cpu_access(pick_addr(), 1'b0, 2'b11, '0);
      test_done("decode and read");
      for (int n = 0; n < 30; n++) cpu_access(pick_addr(), 1'b1, rand_bits(2), rand_bits(16));
      test_done("write");

      // dma during a cpu cycle, both controllers at once
      @(negedge wb_clk);
      cpu_m = '{adr: 16'o001000, dat: '0, cyc: 1'b1, we: 1'b0, sel: 2'b11, stb: 1'b1};
      rk_m  = '{adr: 16'o002000, dat: 16'hA5A5, we: 1'b1, stb: 1'b1};
      my_m  = '{adr: 16'o177400, dat: '0, we: 1'b0, stb: 1'b1};
      rk_req = 1'b1;
      my_req = 1'b1;
      @(posedge wb_clk);
      t = 0;
      while (!cpu_ack && t < 20) begin
         check_eq(rk_gnt | my_gnt, 1'b0, "dma grant while cpu cycle active");
         @(posedge wb_clk);
         t++;
      end
      if (!cpu_ack) begin
         $display("no acknowledge for the cpu cycle ahead of the dma at %0t", $time);
         errors++;
      end
      @(negedge wb_clk);
      cpu_m.cyc = 1'b0;
      cpu_m.stb = 1'b0;
      @(posedge wb_clk);
      wait_high(rk_gnt, "rk grant");
      check_eq({my_gnt, bus_cyc, bus.sel}, {1'b0, 1'b1, 2'b11}, "rk first with full word");
      wait_high(rk_ack, "rk ack");
      check_eq(cpu_ack, 1'b0, "cpu ack during rk access");
      @(negedge wb_clk);
      rk_req = 1'b0;
      rk_m.stb = 1'b0;
      @(posedge wb_clk);
      wait_high(my_gnt, "my grant");
      check_eq({rk_gnt, bus_cyc, bus.sel}, {1'b0, 1'b1, 2'b11}, "my owns with full word");
      wait_high(my_ack, "my ack");
      check_eq({cpu_ack, rd_dat}, {1'b0, slave_word(SLV_RK, 16'o177400)}, "my read");
      @(negedge wb_clk);
      my_req = 1'b0;
      my_m.stb = 1'b0;
      @(posedge wb_clk);
      wait_high(cpu_gnt, "cpu grant back");
      test_done("dma arbitration");

      // sd dispatcher against a cycle model
      for (int n = 0; n < 400; n++) begin
         @(negedge wb_clk);
         drive_clients();
         @(posedge wb_clk);
         check_eq(sd_ack, ack_m, "sd ack");
         check_eq($countones(sd_ack) <= 1, 1'b1, "sd grants overlap");
         if (ack_m != 0) begin
            for (int i = 0; i < N_SD; i++) begin
               if (ack_m[i]) own = i;      // client holding the card
            end
            check_eq({sdcard_cs, sdcard_mosi}, {sd_cs[own], sd_mosi[own]}, "card lines");
         end else begin
            check_eq({sdcard_cs, sdcard_mosi}, 2'b11, "idle card lines");
         end
         if (ack_m == 0 && sd_req != 0) begin
            ack_m = sd_req & (~sd_req + 1'b1);   // lowest index wins
            grants++;
         end else if (ack_m != 0 && (sd_req & ack_m) == 0) begin
            ack_m = '0;
         end
      end
      if (grants < 10) begin
         $display("the sd card was granted only %0d times", grants);
         errors++;
      end
      test_done("sd dispatcher");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: design/backplane.sv
//********************
// backplane fabric
// wishbone bus with cpu and two dma masters,
// i/o page decoding and shared sd card access
//********************
module backplane (
   input  logic                 wb_clk,
   input  logic                 rst_n_i,
   // masters
   input  bus_pkg::cpu_master_t cpu_m_i,
   input  logic                 rk_req_i,
   input  bus_pkg::dma_master_t rk_m_i,
   input  logic                 my_req_i,
   input  bus_pkg::dma_master_t my_m_i,
   output logic                 cpu_gnt_o,
   output logic                 rk_gnt_o,
   output logic                 my_gnt_o,
   output logic                 cpu_ack_o,
   output logic                 rk_ack_o,
   output logic                 my_ack_o,
   output bus_pkg::wb_dat_t     rd_dat_o,    // read data to all masters
   // slaves
   output bus_pkg::slave_req_t  bus_o,
   output logic                 bus_cyc_o,
   output bus_pkg::slave_vec_t  slv_stb_o,
   input  bus_pkg::slave_vec_t  slv_ack_i,
   input  bus_pkg::slave_dat_t  slv_dat_i,
   // sd card clients
   input  sd_pkg::sd_vec_t      sd_req_i,
   input  sd_pkg::sd_vec_t      sd_cs_i,
   input  sd_pkg::sd_vec_t      sd_mosi_i,
   output sd_pkg::sd_vec_t      sd_ack_o,
   output logic                 sdcard_cs_o,
   output logic                 sdcard_mosi_o
);

   logic bus_stb;   // muxed strobe
   logic bus_ack;   // or of all slave acks

   //********************
   // bus masters
   //********************
   bus_arbiter i_bus_arbiter (
      .wb_clk    (wb_clk),
      .rst_n_i   (rst_n_i),
      .cpu_m_i   (cpu_m_i),
      .rk_req_i  (rk_req_i),
      .rk_m_i    (rk_m_i),
      .my_req_i  (my_req_i),
      .my_m_i    (my_m_i),
      .bus_ack_i (bus_ack),
      .bus_o     (bus_o),
      .bus_cyc_o (bus_cyc_o),
      .bus_stb_o (bus_stb),
      .cpu_gnt_o (cpu_gnt_o),
      .rk_gnt_o  (rk_gnt_o),
      .my_gnt_o  (my_gnt_o),
      .cpu_ack_o (cpu_ack_o),
      .rk_ack_o  (rk_ack_o),
      .my_ack_o  (my_ack_o)
   );

   //********************
   // slave side
   //********************
   io_decoder i_io_decoder (
      .bus_i     (bus_o),
      .bus_cyc_i (bus_cyc_o),
      .bus_stb_i (bus_stb),
      .slv_ack_i (slv_ack_i),
      .slv_dat_i (slv_dat_i),
      .slv_stb_o (slv_stb_o),
      .bus_ack_o (bus_ack),
      .rd_dat_o  (rd_dat_o)
   );

   // sd card sharing
   sd_dispatcher i_sd_dispatcher (
      .wb_clk        (wb_clk),
      .rst_n_i       (rst_n_i),
      .sd_req_i      (sd_req_i),
      .sd_cs_i       (sd_cs_i),
      .sd_mosi_i     (sd_mosi_i),
      .sd_ack_o      (sd_ack_o),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o)
   );

endmodule

// File: design/sd_dispatcher.sv
//********************
// sd card dispatcher
// grants the single card to one disk controller
// at a time by four phase req/ack, rk first,
// and muxes that controller's cs and mosi
//********************
module sd_dispatcher (
   input  logic             wb_clk,
   input  logic             rst_n_i,
   input  sd_pkg::sd_vec_t  sd_req_i,    // card requests
   input  sd_pkg::sd_vec_t  sd_cs_i,     // client chip selects
   input  sd_pkg::sd_vec_t  sd_mosi_i,   // client mosi
   output sd_pkg::sd_vec_t  sd_ack_o,    // card grants
   output logic             sdcard_cs_o,
   output logic             sdcard_mosi_o
);

   import sd_pkg::*;

   sd_owner_e state_q;
   logic      owner_req;   // owner still wants the card

   //********************
   // grant fsm
   //********************
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         state_q <= SD_FREE;
      end else if (state_q == SD_FREE) begin
         // pick highest priority requester
         if (sd_req_i[SD_RK]) begin
            state_q <= SD_OWN_RK;
         end else if (sd_req_i[SD_DW]) begin
            state_q <= SD_OWN_DW;
         end else if (sd_req_i[SD_DX]) begin
            state_q <= SD_OWN_DX;
         end else if (sd_req_i[SD_MY]) begin
            state_q <= SD_OWN_MY;
         end
      end else if (!owner_req) begin
         state_q <= SD_FREE;          // owner done, ack drops next
      end
   end

   // ack decoded from state
   always_comb begin
      sd_ack_o = '0;
      case (state_q)
         SD_OWN_RK: sd_ack_o[SD_RK] = 1'b1;
         SD_OWN_DW: sd_ack_o[SD_DW] = 1'b1;
         SD_OWN_DX: sd_ack_o[SD_DX] = 1'b1;
         SD_OWN_MY: sd_ack_o[SD_MY] = 1'b1;
         default:   sd_ack_o = '0;
      endcase
   end

   assign owner_req = |(sd_req_i & sd_ack_o);

   //********************
   // card line mux
   //********************
   assign sdcard_cs_o   = (state_q == SD_FREE) ? SD_IDLE_CS   : |(sd_cs_i & sd_ack_o);
   assign sdcard_mosi_o = (state_q == SD_FREE) ? SD_IDLE_MOSI : |(sd_mosi_i & sd_ack_o);

endmodule

// File: design/io_decoder.sv
//********************
// address decoder of the backplane
// ram, user rom and i/o page windows,
// global ack and read data mux
// fully combinational
//********************
module io_decoder (
   input  bus_pkg::slave_req_t bus_i,
   input  logic                bus_cyc_i,
   input  logic                bus_stb_i,
   input  bus_pkg::slave_vec_t slv_ack_i,
   input  bus_pkg::slave_dat_t slv_dat_i,
   output bus_pkg::slave_vec_t slv_stb_o,
   output logic                bus_ack_o,
   output bus_pkg::wb_dat_t    rd_dat_o
);

   import bus_pkg::*;

   slave_vec_t hit;      // raw window match
   logic       access;   // active bus cycle

   // true if adr falls in the window at base,
   // low lsb bits are register offset
   function automatic logic win_hit(
      input wb_adr_t     adr,
      input wb_adr_t     base,
      input int unsigned lsb
   );
      return (adr >> lsb) == (base >> lsb);
   endfunction

   //********************
   // window match
   //********************
   always_comb begin
      hit = '0;
      // main memory 000000-137777
      hit[SLV_RAM]   = (bus_i.adr[ADR_W-1 -: 2] != RAM_TOP);
      // user rom 140000-157777
      hit[SLV_ROM]   = win_hit(bus_i.adr, ROM_BASE, ROM_LSB);
      // i/o page 160000-177777
      hit[SLV_UART1] = win_hit(bus_i.adr, UART1_BASE, UART1_LSB);   // 177560-177566
      hit[SLV_UART2] = win_hit(bus_i.adr, UART2_BASE, UART2_LSB);   // 176500-176506
      hit[SLV_LPT]   = win_hit(bus_i.adr, LPT_BASE, LPT_LSB);       // 177514-177516
      hit[SLV_RK]    = win_hit(bus_i.adr, RK_BASE, RK_LSB);         // 177400-177416
      hit[SLV_DW]    = win_hit(bus_i.adr, DW_BASE, DW_LSB);         // 174000-174036
      hit[SLV_RX]    = win_hit(bus_i.adr, RX_BASE, RX_LSB);         // 177170-177172
      hit[SLV_MY]    = win_hit(bus_i.adr, MY_BASE, MY_LSB);         // 172140-172142
      hit[SLV_KGD]   = win_hit(bus_i.adr, KGD_BASE, KGD_LSB);       // 176640-176646
   end

   // windows are disjoint, so at most one strobe
   // unmapped i/o page address selects nobody and the master stalls
   assign access    = bus_cyc_i & bus_stb_i;
   assign slv_stb_o = access ? hit : '0;

   //********************
   // ack and read data
   //********************
   assign bus_ack_o = |slv_ack_i;   // any slave answering

   // and-or mux, only the selected slave contributes
   always_comb begin
      rd_dat_o = '0;
      for (int i = 0; i < N_SLAVES; i++) begin
         rd_dat_o = rd_dat_o | (slv_dat_i[i] & {DAT_W{slv_stb_o[i]}});
      end
   end

endmodule

// File: design/bus_arbiter.sv
//********************
// dma arbiter and master mux
// picks cpu, rk or my as owner of the common bus,
// switches only between cycles, rk wins over my
// steers the owner's lines to the slaves
//********************
module bus_arbiter (
   input  logic                 wb_clk,
   input  logic                 rst_n_i,
   // cpu board
   input  bus_pkg::cpu_master_t cpu_m_i,
   // rk11 dma
   input  logic                 rk_req_i,
   input  bus_pkg::dma_master_t rk_m_i,
   // my dma
   input  logic                 my_req_i,
   input  bus_pkg::dma_master_t my_m_i,
   // global ack from decoder
   input  logic                 bus_ack_i,
   // common bus
   output bus_pkg::slave_req_t  bus_o,
   output logic                 bus_cyc_o,
   output logic                 bus_stb_o,
   // grants
   output logic                 cpu_gnt_o,
   output logic                 rk_gnt_o,
   output logic                 my_gnt_o,
   // routed acks
   output logic                 cpu_ack_o,
   output logic                 rk_ack_o,
   output logic                 my_ack_o
);

   import bus_pkg::*;

   bus_owner_e owner_q;   // current bus owner

   //********************
   // ownership
   //********************
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         owner_q <= OWN_CPU;               // cpu owns the bus after reset
      end else if (!bus_cyc_o) begin       // change only while idle
         if (rk_req_i) begin
            owner_q <= OWN_RK;
         end else if (my_req_i) begin
            owner_q <= OWN_MY;
         end else begin
            owner_q <= OWN_CPU;            // no dma pending
         end
      end
   end

   //********************
   // master mux
   //********************
   always_comb begin
      case (owner_q)
         OWN_RK: begin
            bus_o.adr = rk_m_i.adr;
            bus_o.dat = rk_m_i.dat;
            bus_o.we  = rk_m_i.we;
            bus_o.sel = '1;                // dma moves whole words
            bus_cyc_o = rk_req_i;          // request doubles as cyc
            bus_stb_o = rk_m_i.stb;
         end
         OWN_MY: begin
            bus_o.adr = my_m_i.adr;
            bus_o.dat = my_m_i.dat;
            bus_o.we  = my_m_i.we;
            bus_o.sel = '1;
            bus_cyc_o = my_req_i;
            bus_stb_o = my_m_i.stb;
         end
         default: begin                    // cpu
            bus_o.adr = cpu_m_i.adr;
            bus_o.dat = cpu_m_i.dat;
            bus_o.we  = cpu_m_i.we;
            bus_o.sel = cpu_m_i.sel;
            bus_cyc_o = cpu_m_i.cyc;
            bus_stb_o = cpu_m_i.stb;
         end
      endcase
   end

   // grants straight from the owner register
   assign cpu_gnt_o = (owner_q == OWN_CPU);
   assign rk_gnt_o  = (owner_q == OWN_RK);
   assign my_gnt_o  = (owner_q == OWN_MY);

   // ack goes back to the owner only
   // an ungranted cpu just waits for its ack
   assign cpu_ack_o = cpu_gnt_o & bus_ack_i;
   assign rk_ack_o  = rk_gnt_o & bus_ack_i;
   assign my_ack_o  = my_gnt_o & bus_ack_i;

endmodule

// File: design/sd_pkg.sv
//********************
// sd card sharing definitions
// client numbering, state encoding
// and idle card line levels
//********************
package sd_pkg;

   localparam int unsigned N_SD = 4;   // disk controllers sharing the card

   typedef logic [N_SD-1:0] sd_vec_t;   // one bit per client

   // index order is grant priority, rk first
   localparam int unsigned SD_RK = 0;
   localparam int unsigned SD_DW = 1;
   localparam int unsigned SD_DX = 2;
   localparam int unsigned SD_MY = 3;

   //********************
   // dispatcher states
   //********************
   typedef enum logic [2:0] {
      SD_FREE,     // nobody holds the card
      SD_OWN_RK,
      SD_OWN_DW,
      SD_OWN_DX,
      SD_OWN_MY
   } sd_owner_e;

   // card lines while free
   localparam logic SD_IDLE_CS   = 1'b1;   // card deselected
   localparam logic SD_IDLE_MOSI = 1'b1;

endpackage

// File: design/bus_pkg.sv
//********************
// backplane bus definitions
// word widths, master and slave bundles,
// slave numbering and i/o page address map
//********************
package bus_pkg;

   //********************
   // widths
   //********************
   localparam int unsigned ADR_W = 16;   // byte address
   localparam int unsigned DAT_W = 16;   // one word
   localparam int unsigned SEL_W = 2;    // low and high byte

   typedef logic [ADR_W-1:0] wb_adr_t;
   typedef logic [DAT_W-1:0] wb_dat_t;
   typedef logic [SEL_W-1:0] wb_sel_t;

   // what the cpu board puts on the bus
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      logic    cyc;
      logic    we;
      wb_sel_t sel;
      logic    stb;
   } cpu_master_t;

   // dma side of a disk controller, req line acts as cyc
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      logic    we;    // 1 = disk to memory
      logic    stb;
   } dma_master_t;

   // common bus as seen by every slave
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      logic    we;
      wb_sel_t sel;
   } slave_req_t;

   //********************
   // slave map
   //********************
   localparam int unsigned N_SLAVES = 10;

   typedef logic [N_SLAVES-1:0]    slave_vec_t;   // one bit per slave
   typedef wb_dat_t [N_SLAVES-1:0] slave_dat_t;   // read word per slave

   localparam int unsigned SLV_RAM   = 0;
   localparam int unsigned SLV_ROM   = 1;
   localparam int unsigned SLV_UART1 = 2;   // console
   localparam int unsigned SLV_UART2 = 3;
   localparam int unsigned SLV_LPT   = 4;
   localparam int unsigned SLV_RK    = 5;
   localparam int unsigned SLV_DW    = 6;
   localparam int unsigned SLV_RX    = 7;
   localparam int unsigned SLV_MY    = 8;
   localparam int unsigned SLV_KGD   = 9;

   // i/o windows, base plus number of ignored low bits
   localparam wb_adr_t     UART1_BASE = 16'o177560;
   localparam int unsigned UART1_LSB  = 3;
   localparam wb_adr_t     UART2_BASE = 16'o176500;
   localparam int unsigned UART2_LSB  = 3;
   localparam wb_adr_t     LPT_BASE   = 16'o177514;
   localparam int unsigned LPT_LSB    = 2;
   localparam wb_adr_t     RK_BASE    = 16'o177400;
   localparam int unsigned RK_LSB     = 4;
   localparam wb_adr_t     DW_BASE    = 16'o174000;
   localparam int unsigned DW_LSB     = 5;
   localparam wb_adr_t     RX_BASE    = 16'o177170;
   localparam int unsigned RX_LSB     = 2;
   localparam wb_adr_t     MY_BASE    = 16'o172140;
   localparam int unsigned MY_LSB     = 2;
   localparam wb_adr_t     KGD_BASE   = 16'o176640;
   localparam int unsigned KGD_LSB    = 3;
   localparam wb_adr_t     ROM_BASE   = 16'o140000;   // user rom 140000-157777
   localparam int unsigned ROM_LSB    = 13;
   localparam logic [1:0]  RAM_TOP    = 2'b11;        // ram is below 140000

   // who owns the common bus
   typedef enum logic [1:0] {
      OWN_CPU,
      OWN_RK,
      OWN_MY
   } bus_owner_e;

endpackage
